// ==== design/mmix_isa_pkg.sv ====
/*
 * MMIX opcode constants, internal operation codes and decode flag masks.
 * Only the opcodes that the front end classifies or emits get a constant here.
 * Flags are masks into one 8-bit word, so they combine with a plain OR.
 */
`default_nettype none

package mmix_isa_pkg;

	// opcode group bases, each names the first opcode of its row
	localparam logic [7:0] TRAP = 8'h00;
	localparam logic [7:0] ADD  = 8'h20;
	localparam logic [7:0] CMP  = 8'h30;  // CMP..NEGUI
	localparam logic [7:0] SL   = 8'h38;
	localparam logic [7:0] BN   = 8'h40;
	localparam logic [7:0] BNN  = 8'h48;
	localparam logic [7:0] PBN  = 8'h50;
	localparam logic [7:0] PBNN = 8'h58;
	localparam logic [7:0] LDB  = 8'h80;
	localparam logic [7:0] LDOU = 8'h8e;  // last row of plain loads
	localparam logic [7:0] GO   = 8'h9e;
	localparam logic [7:0] STB  = 8'ha0;
	localparam logic [7:0] STOU = 8'hae;  // also the op of an inserted spill
	localparam logic [7:0] STCO = 8'hb4;
	localparam logic [7:0] OR   = 8'hc0;
	localparam logic [7:0] AND  = 8'hc8;
	localparam logic [7:0] SETH = 8'he0;  // also the op of an inserted incrl
	localparam logic [7:0] ORH  = 8'he8;
	localparam logic [7:0] JMP  = 8'hf0;
	localparam logic [7:0] GETA = 8'hf4;
	localparam logic [7:0] TRIP = 8'hff;

	// operations as the execution units see them
	typedef enum logic [4:0] {
		trap,
		noop,
		add,
		addu,
		sub,
		subu,
		cmp,
		cmpu,
		shl,
		shlu,
		shr,
		shru,
		br,
		pbr,
		ld,
		st,
		go,
		or_,
		orn,
		nor_,
		xor_,
		and_,
		andn,
		nand_,
		nxor,
		set,
		jmp,
		incrl,     // inserted: make a marginal register local
		incgamma   // inserted: spill one ring slot to memory
	} internal_op_e;

	typedef logic [7:0] op_flags_t;

	localparam op_flags_t Z_IMM      = 8'h01;  // Z field is an immediate
	localparam op_flags_t Z_REG      = 8'h02;  // $Z is a source
	localparam op_flags_t Y_IMM      = 8'h04;  // Y field is an immediate
	localparam op_flags_t Y_REG      = 8'h08;  // $Y is a source
	localparam op_flags_t X_SRC      = 8'h10;  // $X is read
	localparam op_flags_t X_DEST     = 8'h20;  // $X is written
	localparam op_flags_t REL_ADDR   = 8'h40;  // YZ or XYZ is a relative offset
	localparam op_flags_t CTL_CHANGE = 8'h80;  // control flow leaves the sequence

endpackage

`default_nettype wire

// ==== design/mmix_decode_pkg.sv ====
/*
 * Decode-side structures: operand specs, renamed destination, stack pointers
 * and the control word. The local ring is fixed at 256 slots; ring slot
 * addresses wrap on that size.
 */
`default_nettype none

package mmix_decode_pkg;

	localparam int LRING_SIZE = 256;
	localparam int STACK_PTR_W = 62;  // S and O count octabytes
	localparam logic [STACK_PTR_W-1:0] LRING_MASK = STACK_PTR_W'(LRING_SIZE - 1);

	typedef enum logic [1:0] {
		src_none   = 2'd0,
		src_global = 2'd1,
		src_local  = 2'd2
	} src_kind_e;

	typedef struct packed {
		logic [63:0] o;     // value when already known
		src_kind_e   src;   // register file that holds it otherwise
		logic [7:0]  addr;
	} spec_t;

	typedef struct packed {
		logic       ren;  // X gets a fresh rename
		src_kind_e  src;
		logic [7:0] addr;
	} dest_t;

	typedef struct packed {
		logic [63:0] loc;
		logic [31:0] inst;
	} fetch_t;

	typedef struct packed {
		logic [7:0]             l;
		logic [STACK_PTR_W-1:0] s;  // gamma, oldest slot still in the ring
		logic [STACK_PTR_W-1:0] o;  // alpha, base of the current frame
	} stack_state_t;

	typedef struct packed {
		logic [63:0]                loc;
		logic [7:0]                 op;
		logic [7:0]                 xx;
		logic [7:0]                 yy;
		logic [7:0]                 zz;
		mmix_isa_pkg::internal_op_e i;
		spec_t                      y;
		spec_t                      z;
		spec_t                      b;
		dest_t                      x;
		logic                       interim;  // stack bookkeeping, not the program's own
		logic                       mem_x;    // result goes to memory
	} control_t;

	// ring slot of local register r in the frame based at o
	function automatic logic [7:0] ring_slot(input logic [STACK_PTR_W-1:0] o,
			input logic [7:0] r);
		logic [STACK_PTR_W-1:0] sum;
		sum = (o + STACK_PTR_W'(r)) & LRING_MASK;
		return sum[7:0];
	endfunction

	// register operand: global at or above G, ring slot below it
	function automatic spec_t reg_spec(input logic [7:0] r, input logic [7:0] g,
			input logic [STACK_PTR_W-1:0] o);
		spec_t s;
		s = '0;
		if (r >= g) begin
			s.src = src_global;
			s.addr = r;
		end else begin
			s.src = src_local;
			s.addr = ring_slot(o, r);
		end
		return s;
	endfunction

endpackage

`default_nettype wire

// ==== design/opcode_classifier.sv ====
/*
 * Opcode to internal operation and flag word, purely combinational.
 * Anything outside the supported rows comes out as trap with TRAP flags.
 * TRIP is a trap at user level and a no-op in the negative half of memory.
 */
`timescale 1ns/1ps
`default_nettype none

module opcode_classifier (
	input  logic [31:0]                inst,
	input  logic [63:0]                loc,
	output mmix_isa_pkg::internal_op_e i,
	output mmix_isa_pkg::op_flags_t    flags
);

	logic [7:0] op;
	logic supported;
	mmix_isa_pkg::internal_op_e op_i;
	mmix_isa_pkg::op_flags_t op_f;
	mmix_isa_pkg::op_flags_t z_f;     // odd opcodes carry Z as an immediate
	mmix_isa_pkg::op_flags_t trap_f;

	// four operations per row, picked by op[2:1]
	function automatic mmix_isa_pkg::internal_op_e pick4(input logic [1:0] sel,
			input mmix_isa_pkg::internal_op_e a, input mmix_isa_pkg::internal_op_e b,
			input mmix_isa_pkg::internal_op_e c, input mmix_isa_pkg::internal_op_e d);
		case (sel)
		2'd0: return a;
		2'd1: return b;
		2'd2: return c;
		default: return d;
		endcase
	endfunction

	assign op = inst[31:24];
	assign z_f = op[0] ? mmix_isa_pkg::Z_IMM : mmix_isa_pkg::Z_REG;
	assign trap_f = mmix_isa_pkg::CTL_CHANGE | mmix_isa_pkg::Y_REG | mmix_isa_pkg::Z_REG;

	always_comb begin
		supported = 1'b1;
		op_i = mmix_isa_pkg::trap;
		op_f = trap_f;
		case (op[7:3])
		mmix_isa_pkg::TRAP[7:3]: supported = (op == mmix_isa_pkg::TRAP);  // rest are floats
		mmix_isa_pkg::ADD[7:3]: begin
			op_i = pick4(op[2:1], mmix_isa_pkg::add, mmix_isa_pkg::addu,
				mmix_isa_pkg::sub, mmix_isa_pkg::subu);
			op_f = mmix_isa_pkg::X_DEST | mmix_isa_pkg::Y_REG | z_f;
		end
		mmix_isa_pkg::CMP[7:3]: begin
			op_i = pick4(op[2:1], mmix_isa_pkg::cmp, mmix_isa_pkg::cmpu,
				mmix_isa_pkg::sub, mmix_isa_pkg::subu);
			// NEG takes Y as an immediate minuend
			op_f = mmix_isa_pkg::X_DEST | z_f
				| (op[2] ? mmix_isa_pkg::Y_IMM : mmix_isa_pkg::Y_REG);
		end
		mmix_isa_pkg::SL[7:3]: begin
			op_i = pick4(op[2:1], mmix_isa_pkg::shl, mmix_isa_pkg::shlu,
				mmix_isa_pkg::shr, mmix_isa_pkg::shru);
			op_f = mmix_isa_pkg::X_DEST | mmix_isa_pkg::Y_REG | z_f;
		end
		mmix_isa_pkg::BN[7:3], mmix_isa_pkg::BNN[7:3]: begin
			op_i = mmix_isa_pkg::br;
			op_f = mmix_isa_pkg::REL_ADDR | mmix_isa_pkg::X_SRC;  // $X is the tested value
		end
		mmix_isa_pkg::PBN[7:3], mmix_isa_pkg::PBNN[7:3]: begin
			op_i = mmix_isa_pkg::pbr;
			op_f = mmix_isa_pkg::REL_ADDR | mmix_isa_pkg::X_SRC;
		end
		mmix_isa_pkg::LDB[7:3], mmix_isa_pkg::LDOU[7:3]: begin
			op_i = mmix_isa_pkg::ld;
			op_f = mmix_isa_pkg::X_DEST | mmix_isa_pkg::Y_REG | z_f;
		end
		mmix_isa_pkg::GO[7:3]: begin
			supported = (op[7:1] == mmix_isa_pkg::GO[7:1]);  // LDVTS, PRELD, PREGO are not
			op_i = mmix_isa_pkg::go;
			op_f = mmix_isa_pkg::CTL_CHANGE | mmix_isa_pkg::X_DEST | mmix_isa_pkg::Y_REG | z_f;
		end
		mmix_isa_pkg::STB[7:3], mmix_isa_pkg::STOU[7:3]: begin
			op_i = mmix_isa_pkg::st;
			op_f = mmix_isa_pkg::X_SRC | mmix_isa_pkg::Y_REG | z_f;
		end
		mmix_isa_pkg::STCO[7:3]: begin
			supported = (op[7:1] == mmix_isa_pkg::STCO[7:1]);
			op_i = mmix_isa_pkg::st;
			op_f = mmix_isa_pkg::Y_REG | z_f;  // X is a constant here
		end
		mmix_isa_pkg::OR[7:3]: begin
			op_i = pick4(op[2:1], mmix_isa_pkg::or_, mmix_isa_pkg::orn,
				mmix_isa_pkg::nor_, mmix_isa_pkg::xor_);
			op_f = mmix_isa_pkg::X_DEST | mmix_isa_pkg::Y_REG | z_f;
		end
		mmix_isa_pkg::AND[7:3]: begin
			op_i = pick4(op[2:1], mmix_isa_pkg::and_, mmix_isa_pkg::andn,
				mmix_isa_pkg::nand_, mmix_isa_pkg::nxor);
			op_f = mmix_isa_pkg::X_DEST | mmix_isa_pkg::Y_REG | z_f;
		end
		mmix_isa_pkg::SETH[7:3]: begin
			op_i = op[2] ? mmix_isa_pkg::addu : mmix_isa_pkg::set;  // INCx adds to $X
			op_f = op[2] ? (mmix_isa_pkg::X_DEST | mmix_isa_pkg::X_SRC) : mmix_isa_pkg::X_DEST;
		end
		mmix_isa_pkg::ORH[7:3]: begin
			op_i = op[2] ? mmix_isa_pkg::andn : mmix_isa_pkg::or_;
			op_f = mmix_isa_pkg::X_DEST | mmix_isa_pkg::X_SRC;
		end
		mmix_isa_pkg::JMP[7:3]: begin
			if (op[7:1] == mmix_isa_pkg::JMP[7:1]) begin
				op_i = mmix_isa_pkg::jmp;
				op_f = mmix_isa_pkg::CTL_CHANGE | mmix_isa_pkg::REL_ADDR;
			end else if (op[7:1] == mmix_isa_pkg::GETA[7:1]) begin
				op_i = mmix_isa_pkg::set;  // GETA just sets $X to the address
				op_f = mmix_isa_pkg::X_DEST | mmix_isa_pkg::REL_ADDR;
			end else begin
				supported = 1'b0;  // PUSHJ, PUT
			end
		end
		mmix_isa_pkg::TRIP[7:3]: begin
			supported = (op == mmix_isa_pkg::TRIP);
			if (loc[63]) begin
				op_i = mmix_isa_pkg::noop;
				op_f = '0;
			end
		end
		default: supported = 1'b0;
		endcase
	end

	assign i = supported ? op_i : mmix_isa_pkg::trap;
	assign flags = supported ? op_f : trap_f;

	// no row of the table may ask for Z both ways
	always_comb begin
		assert (!((flags & mmix_isa_pkg::Z_IMM) != '0 && (flags & mmix_isa_pkg::Z_REG) != '0))
			else $error("opcode %h flags Z as immediate and register", op);
	end

endmodule

`default_nettype wire

// ==== design/operand_decoder.sv ====
/*
 * Y and Z field resolution, combinational from the fetch and current O.
 * Relative offsets use the opcode's backward bit as the sign, as MMIX does.
 * For the wyde row, Z is the shifted YZ and Y names register X.
 */
`timescale 1ns/1ps
`default_nettype none

module operand_decoder (
	input  mmix_decode_pkg::fetch_t       fetch,
	input  logic [7:0]                    G,
	input  mmix_decode_pkg::stack_state_t state,
	input  mmix_isa_pkg::op_flags_t       flags,
	output mmix_decode_pkg::spec_t        y,
	output mmix_decode_pkg::spec_t        z
);

	logic [7:0] op;
	logic [7:0] xx;
	logic [7:0] yy;
	logic [7:0] zz;
	logic wyde;       // SETH..ANDNL
	logic rel_addr;
	logic [5:0] wyde_shift;

	assign op = fetch.inst[31:24];
	assign xx = fetch.inst[23:16];
	assign yy = fetch.inst[15:8];
	assign zz = fetch.inst[7:0];
	assign wyde = (op[7:4] == 4'he);
	assign rel_addr = (flags & mmix_isa_pkg::REL_ADDR) != '0;
	assign wyde_shift = {~op[1:0], 4'b0000};  // H 48, MH 32, ML 16, L 0

	always_comb begin
		y = '0;
		z = '0;
		if (rel_addr) begin
			y.o = fetch.loc + 64'd4;  // return point
			if (op[7:1] == mmix_isa_pkg::JMP[7:1])
				z.o = fetch.loc + {{38{op[0]}}, fetch.inst[23:0], 2'b00};  // XYZ tetras
			else
				z.o = fetch.loc + {{46{op[0]}}, fetch.inst[15:0], 2'b00};  // YZ tetras
		end else if (wyde) begin
			z.o = {48'd0, fetch.inst[15:0]} << wyde_shift;
			y = mmix_decode_pkg::reg_spec(xx, G, state.o);
		end else begin
			// Z first
			if ((flags & mmix_isa_pkg::Z_IMM) != '0)
				z.o = {56'd0, zz};
			else if ((flags & mmix_isa_pkg::Z_REG) != '0)
				z = mmix_decode_pkg::reg_spec(zz, G, state.o);

			if ((flags & mmix_isa_pkg::Y_IMM) != '0)
				y.o = {56'd0, yy};  // NEG minuend
			else if ((flags & mmix_isa_pkg::Y_REG) != '0)
				y = mmix_decode_pkg::reg_spec(yy, G, state.o);
		end
	end

endmodule

`default_nettype wire

// ==== design/stack_dispatch.sv ====
/*
 * Register stack state, X renaming and stack instruction insertion.
 * While X is marginal the fetch must hold still; one incrl or incgamma is
 * emitted per edge until X becomes local. Control word leaves one cycle later.
 */
`timescale 1ns/1ps
`default_nettype none

module stack_dispatch (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          fetch_valid,
	input  mmix_decode_pkg::fetch_t       fetch,
	input  logic [7:0]                    G,
	input  mmix_isa_pkg::internal_op_e    i,
	input  mmix_isa_pkg::op_flags_t       flags,
	input  mmix_decode_pkg::spec_t        y,
	input  mmix_decode_pkg::spec_t        z,
	output mmix_decode_pkg::stack_state_t state,
	output logic                          stall,
	output logic                          ctl_valid,
	output mmix_decode_pkg::control_t     ctl
);

	logic [7:0] xx;
	logic x_dest;
	logic x_src;
	logic x_named;    // X already lives in a register file
	logic marginal;   // L <= X < G
	logic ring_full;
	logic [mmix_decode_pkg::STACK_PTR_W-1:0] gap;
	mmix_decode_pkg::spec_t x_spec;
	mmix_decode_pkg::control_t nxt;
	mmix_decode_pkg::stack_state_t state_nxt;

	assign xx = fetch.inst[23:16];
	assign x_dest = (flags & mmix_isa_pkg::X_DEST) != '0;
	assign x_src = (flags & mmix_isa_pkg::X_SRC) != '0;
	assign x_named = (xx >= G) || (xx < state.l);
	assign marginal = x_dest && !x_named;
	assign stall = fetch_valid && marginal;

	// free slots left in the ring, zero means one more local would overwrite gamma
	assign gap = state.s - state.o - mmix_decode_pkg::STACK_PTR_W'(state.l)
		- mmix_decode_pkg::STACK_PTR_W'(1);
	assign ring_full = (gap & mmix_decode_pkg::LRING_MASK) == '0;

	assign x_spec = mmix_decode_pkg::reg_spec(xx, G, state.o);

	always_comb begin
		nxt = '0;
		nxt.loc = fetch.loc;
		{nxt.op, nxt.xx, nxt.yy, nxt.zz} = fetch.inst;
		state_nxt = state;
		if (marginal) begin
			nxt.interim = 1'b1;
			if (ring_full) begin
				// store the slot at gamma, then gamma moves up
				nxt.i = mmix_isa_pkg::incgamma;
				nxt.op = mmix_isa_pkg::STOU;
				nxt.y.o = 64'(state.s);
				nxt.mem_x = 1'b1;
				state_nxt.s = state.s + 1'b1;
			end else begin
				nxt.i = mmix_isa_pkg::incrl;
				nxt.op = mmix_isa_pkg::SETH;  // simplest unit clears the new local
				nxt.x.ren = 1'b1;
				nxt.x.src = mmix_decode_pkg::src_local;
				nxt.x.addr = mmix_decode_pkg::ring_slot(state.o, state.l);
				state_nxt.l = state.l + 8'd1;
			end
		end else begin
			nxt.i = i;
			nxt.y = y;
			nxt.z = z;
			if (x_dest) begin  // not marginal, so global or below L
				nxt.x.ren = 1'b1;
				nxt.x.src = x_spec.src;
				nxt.x.addr = x_spec.addr;
			end
			if (x_src && x_named)
				nxt.b = x_spec;
			else if (nxt.op[7:1] == mmix_isa_pkg::STCO[7:1])
				nxt.b.o = {56'd0, xx};  // STCO stores the X field itself
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= '0;
			ctl_valid <= 1'b0;
		end else begin
			ctl_valid <= fetch_valid;  // one word per accepted edge
			if (fetch_valid)
				state <= state_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_valid)
			ctl <= nxt;
	end

	// an accepted incrl only claims registers below G
	assert property (@(posedge clk) disable iff (!arst_n)
		fetch_valid && marginal && !ring_full |=> state.l <= $past(G))
		else $error("L grew past G after incrl");

	assert property (@(posedge clk) !arst_n |=> !ctl_valid)
		else $error("ctl_valid right after a reset cycle");

endmodule

`default_nettype wire

// ==== design/inst_decoder.sv ====
/*
 * Register-stack front end of the dispatch stage.
 * G must hold while fetch_valid is high, and fetch must hold while stall is high.
 * No back-pressure from the output side; ctl is valid for one cycle only.
 */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          fetch_valid,
	input  mmix_decode_pkg::fetch_t       fetch,
	input  logic [7:0]                    G,
	output logic                          stall,
	output logic                          ctl_valid,
	output mmix_decode_pkg::control_t     ctl,
	output mmix_decode_pkg::stack_state_t state
);

	mmix_isa_pkg::internal_op_e i;
	mmix_isa_pkg::op_flags_t flags;
	mmix_decode_pkg::spec_t y;
	mmix_decode_pkg::spec_t z;

	opcode_classifier u_classifier (
		.inst  (fetch.inst),
		.loc   (fetch.loc),
		.i     (i),
		.flags (flags)
	);

	// operands see the state before this edge's update
	operand_decoder u_operands (
		.fetch (fetch),
		.G     (G),
		.state (state),
		.flags (flags),
		.y     (y),
		.z     (z)
	);

	stack_dispatch u_dispatch (
		.clk         (clk),
		.arst_n      (arst_n),
		.fetch_valid (fetch_valid),
		.fetch       (fetch),
		.G           (G),
		.i           (i),
		.flags       (flags),
		.y           (y),
		.z           (z),
		.state       (state),
		.stall       (stall),
		.ctl_valid   (ctl_valid),
		.ctl         (ctl)
	);

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
/*
 * Free-running 40 ns clock and active-low asynchronous reset.
 * Reset releases 1 ns after the 16th rising edge.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk,
	output logic arst_n
);

	localparam int HALF_PERIOD = 20;   // ns
	localparam int RESET_CYCLES = 16;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 arst_n = 1'b1;  // off the edge, like the rest of the stimulus
	end

endmodule

`default_nettype wire

// ==== bench/inst_decoder_tb.sv ====
/*
 * Testbench for the register-stack front end. Stimulus moves 1 ns after the
 * rising edge; outputs are sampled on the falling edge. Expected control words
 * come from a local model of the decode rules and queue up per accepted edge.
 * L stops at 255 from reset, so the ring fill only ever sees incrl.
 */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder_tb;

	localparam int MAX_EDGES = 300;   // longest stall is under 256 edges
	localparam int RESET_WAIT = 40;
	localparam int DRAIN_WAIT = 8;
	localparam logic [7:0] ALU_ROWS [7] = '{8'h20, 8'h30, 8'h38, 8'h80, 8'ha0, 8'hc0, 8'hc8};
	localparam logic [7:0] BAD_OPS [15] = '{8'h01, 8'h1f, 8'h28, 8'h60, 8'h7f, 8'h90, 8'h9d,
		8'hb0, 8'hb6, 8'hbf, 8'hd0, 8'hdf, 8'hf2, 8'hf6, 8'hfe};

	typedef struct packed {
		mmix_decode_pkg::control_t     ctl;
		mmix_decode_pkg::stack_state_t st;  // state right after the edge
	} expect_t;

	logic clk;
	logic arst_n;
	logic fetch_valid;
	mmix_decode_pkg::fetch_t fetch;
	logic [7:0] g;
	logic stall;
	logic ctl_valid;
	mmix_decode_pkg::control_t ctl;
	mmix_decode_pkg::stack_state_t state;
	mmix_decode_pkg::stack_state_t model_st;  // L, S, O as the model sees them
	expect_t expect_q[$];
	int seed = 32'hd3cf;

	tb_clock u_clock (
		.clk    (clk),
		.arst_n (arst_n)
	);

	inst_decoder UUT (
		.clk         (clk),
		.arst_n      (arst_n),
		.fetch_valid (fetch_valid),
		.fetch       (fetch),
		.G           (g),
		.stall       (stall),
		.ctl_valid   (ctl_valid),
		.ctl         (ctl),
		.state       (state)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic expect_equal(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		if (got !== exp)
			fail_run($sformatf("mismatch %s: got %0h expected %0h", name, got, exp));
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		expect_equal(name, {127'd0, got}, {127'd0, exp});
	endtask

	task automatic compare_spec(input string name, input mmix_decode_pkg::spec_t got,
			input mmix_decode_pkg::spec_t exp);
		expect_equal({name, ".o"}, got.o, exp.o);
		expect_equal({name, ".src"}, got.src, exp.src);
		expect_equal({name, ".addr"}, got.addr, exp.addr);
	endtask

	task automatic compare_state(input mmix_decode_pkg::stack_state_t got,
			input mmix_decode_pkg::stack_state_t exp);
		expect_equal("state.l", got.l, exp.l);
		expect_equal("state.s", got.s, exp.s);
		expect_equal("state.o", got.o, exp.o);
	endtask

	task automatic compare_control(input mmix_decode_pkg::control_t got,
			input mmix_decode_pkg::control_t exp);
		expect_equal("ctl.loc", got.loc, exp.loc);
		expect_equal("ctl.op", got.op, exp.op);
		expect_equal("ctl.xx", got.xx, exp.xx);
		expect_equal("ctl.yy", got.yy, exp.yy);
		expect_equal("ctl.zz", got.zz, exp.zz);
		expect_equal("ctl.i", got.i, exp.i);
		compare_spec("ctl.y", got.y, exp.y);
		compare_spec("ctl.z", got.z, exp.z);
		compare_spec("ctl.b", got.b, exp.b);
		expect_equal("ctl.x", got.x, exp.x);
		expect_equal("ctl.interim", got.interim, exp.interim);
		expect_equal("ctl.mem_x", got.mem_x, exp.mem_x);
	endtask

	function automatic logic has_flag(input mmix_isa_pkg::op_flags_t fl,
			input mmix_isa_pkg::op_flags_t m);
		return (fl & m) != '0;
	endfunction

	// k-th operation after first in the enum order
	function automatic mmix_isa_pkg::internal_op_e nth_op(
			input mmix_isa_pkg::internal_op_e first, input int k);
		return mmix_isa_pkg::internal_op_e'(int'(first) + k);
	endfunction

	// globals sit at or above G, locals live in the ring at O + r
	function automatic mmix_decode_pkg::spec_t locate_reg(input logic [7:0] r,
			input logic [7:0] gv, input logic [61:0] o);
		mmix_decode_pkg::spec_t s;
		s = '0;
		s.src = (r >= gv) ? mmix_decode_pkg::src_global : mmix_decode_pkg::src_local;
		s.addr = (r >= gv) ? r : o[7:0] + r;
		return s;
	endfunction

	function automatic void classify(input logic [7:0] op, input logic neg_loc,
			output mmix_isa_pkg::internal_op_e i, output mmix_isa_pkg::op_flags_t fl);
		mmix_isa_pkg::op_flags_t zf;
		mmix_isa_pkg::op_flags_t rd;  // plain X = Y op Z shape
		zf = op[0] ? mmix_isa_pkg::Z_IMM : mmix_isa_pkg::Z_REG;
		rd = mmix_isa_pkg::X_DEST | mmix_isa_pkg::Y_REG | zf;
		i = mmix_isa_pkg::trap;
		fl = mmix_isa_pkg::CTL_CHANGE | mmix_isa_pkg::Y_REG | mmix_isa_pkg::Z_REG;
		if (op inside {[8'h20:8'h27]}) begin
			i = nth_op(mmix_isa_pkg::add, op[2:1]);
			fl = rd;
		end else if (op inside {[8'h30:8'h37]}) begin  // NEG rows take Y as immediate
			i = op[2] ? nth_op(mmix_isa_pkg::sub, op[1]) : nth_op(mmix_isa_pkg::cmp, op[1]);
			fl = mmix_isa_pkg::X_DEST | zf | (op[2] ? mmix_isa_pkg::Y_IMM : mmix_isa_pkg::Y_REG);
		end else if (op inside {[8'h38:8'h3f]}) begin
			i = nth_op(mmix_isa_pkg::shl, op[2:1]);
			fl = rd;
		end else if (op inside {[8'h40:8'h5f]}) begin
			i = op[4] ? mmix_isa_pkg::pbr : mmix_isa_pkg::br;
			fl = mmix_isa_pkg::REL_ADDR | mmix_isa_pkg::X_SRC;
		end else if (op inside {[8'h80:8'h8f]}) begin
			i = mmix_isa_pkg::ld;
			fl = rd;
		end else if (op inside {[8'h9e:8'h9f]}) begin
			i = mmix_isa_pkg::go;
			fl = mmix_isa_pkg::CTL_CHANGE | rd;
		end else if (op inside {[8'ha0:8'haf]}) begin
			i = mmix_isa_pkg::st;
			fl = mmix_isa_pkg::X_SRC | mmix_isa_pkg::Y_REG | zf;
		end else if (op inside {[8'hb4:8'hb5]}) begin  // STCO
			i = mmix_isa_pkg::st;
			fl = mmix_isa_pkg::Y_REG | zf;
		end else if (op inside {[8'hc0:8'hcf]}) begin
			i = nth_op(op[3] ? mmix_isa_pkg::and_ : mmix_isa_pkg::or_, op[2:1]);
			fl = rd;
		end else if (op inside {[8'he0:8'he3]}) begin
			i = mmix_isa_pkg::set;
			fl = mmix_isa_pkg::X_DEST;
		end else if (op inside {[8'he4:8'hef]}) begin  // INC, OR and ANDN wydes read $X
			i = (op[3:2] == 2'b01) ? mmix_isa_pkg::addu
				: (op[2] ? mmix_isa_pkg::andn : mmix_isa_pkg::or_);
			fl = mmix_isa_pkg::X_DEST | mmix_isa_pkg::X_SRC;
		end else if (op inside {[8'hf0:8'hf1]}) begin
			i = mmix_isa_pkg::jmp;
			fl = mmix_isa_pkg::CTL_CHANGE | mmix_isa_pkg::REL_ADDR;
		end else if (op inside {[8'hf4:8'hf5]}) begin  // GETA
			i = mmix_isa_pkg::set;
			fl = mmix_isa_pkg::X_DEST | mmix_isa_pkg::REL_ADDR;
		end else if (op == 8'hff && neg_loc) begin
			i = mmix_isa_pkg::noop;
			fl = '0;
		end
	endfunction

	// expected word for one edge, plus the state after it and the stall level before it
	function automatic mmix_decode_pkg::control_t predict(input mmix_decode_pkg::fetch_t f,
			input logic [7:0] gv, input mmix_decode_pkg::stack_state_t st,
			output mmix_decode_pkg::stack_state_t nst, output logic stall_exp);
		mmix_decode_pkg::control_t c;
		mmix_isa_pkg::internal_op_e i;
		mmix_isa_pkg::op_flags_t fl;
		mmix_decode_pkg::spec_t x_loc;  // where register X lives when named
		logic [7:0] op;
		logic [7:0] xx;
		logic [7:0] yy;
		logic [7:0] zz;
		logic [7:0] free_slots;
		logic x_named;
		logic [63:0] rel;
		{op, xx, yy, zz} = f.inst;
		classify(op, f.loc[63], i, fl);
		c = '0;
		c.loc = f.loc;
		{c.op, c.xx, c.yy, c.zz} = f.inst;
		nst = st;
		x_named = (xx >= gv) || (xx < st.l);
		x_loc = locate_reg(xx, gv, st.o);
		stall_exp = has_flag(fl, mmix_isa_pkg::X_DEST) && !x_named;
		free_slots = st.s[7:0] - st.o[7:0] - st.l - 8'd1;  // ring wraps every 256
		if (stall_exp && free_slots == 8'd0) begin
			c.interim = 1'b1;
			c.i = mmix_isa_pkg::incgamma;
			c.op = mmix_isa_pkg::STOU;
			c.y.o = {2'b00, st.s};
			c.mem_x = 1'b1;
			nst.s = st.s + 62'd1;
		end else if (stall_exp) begin
			c.interim = 1'b1;
			c.i = mmix_isa_pkg::incrl;
			c.op = mmix_isa_pkg::SETH;
			c.x.ren = 1'b1;
			c.x.src = mmix_decode_pkg::src_local;
			c.x.addr = st.o[7:0] + st.l;
			nst.l = st.l + 8'd1;
		end else begin
			c.i = i;
			if (has_flag(fl, mmix_isa_pkg::REL_ADDR)) begin
				c.y.o = f.loc + 64'd4;
				if (op[7:1] == 7'h78) begin  // JMP, 24-bit tetra offset
					rel = {40'd0, f.inst[23:0]};
					if (op[0])
						rel = rel - 64'h100_0000;
				end else begin
					rel = {48'd0, f.inst[15:0]};
					if (op[0])
						rel = rel - 64'h1_0000;
				end
				c.z.o = f.loc + (rel << 2);
			end else if (op[7:4] == 4'he) begin
				c.z.o = {48'd0, f.inst[15:0]} << (16 * (3 - int'(op[1:0])));
				c.y = x_loc;
			end else begin
				if (has_flag(fl, mmix_isa_pkg::Z_IMM))
					c.z.o = {56'd0, zz};
				else if (has_flag(fl, mmix_isa_pkg::Z_REG))
					c.z = locate_reg(zz, gv, st.o);
				if (has_flag(fl, mmix_isa_pkg::Y_IMM))
					c.y.o = {56'd0, yy};
				else if (has_flag(fl, mmix_isa_pkg::Y_REG))
					c.y = locate_reg(yy, gv, st.o);
			end
			if (has_flag(fl, mmix_isa_pkg::X_DEST)) begin
				c.x.ren = 1'b1;
				c.x.src = x_loc.src;
				c.x.addr = x_loc.addr;
			end
			if (has_flag(fl, mmix_isa_pkg::X_SRC) && x_named)
				c.b = x_loc;
			else if (op[7:1] == 7'h5a)
				c.b.o = {56'd0, xx};  // STCO constant
		end
		return c;
	endfunction

	function automatic mmix_decode_pkg::fetch_t pack_fetch(input logic [63:0] loc,
			input logic [7:0] op, input logic [7:0] x, input logic [15:0] yz);
		mmix_decode_pkg::fetch_t f;
		f.loc = loc;
		f.inst = {op, x, yz};
		return f;
	endfunction

	// X below L or at or above G, so never marginal
	function automatic logic [7:0] pick_named_x(input logic [7:0] gv, input logic [7:0] l,
			input logic [31:0] r);
		if (l != 8'd0 && r[31])
			return r[7:0] % l;
		else
			return 8'(int'(gv) + int'(r[15:8]) % (256 - int'(gv)));
	endfunction

	// called 1 ns after a rising edge; returns once the instruction itself is accepted
	task automatic issue(input mmix_decode_pkg::fetch_t f, input logic [7:0] gv);
		expect_t e;
		mmix_decode_pkg::stack_state_t nst;
		logic exp_stall;
		int n;
		fetch = f;
		g = gv;
		fetch_valid = 1'b1;
		exp_stall = 1'b1;
		n = 0;
		while (exp_stall) begin
			if (n == MAX_EDGES)
				fail_run($sformatf("instruction %h still stalled after %0d edges", f.inst, n));
			e.ctl = predict(f, gv, model_st, nst, exp_stall);
			e.st = nst;
			@(negedge clk);
			check_level("stall", stall, exp_stall);
			@(posedge clk);
			#1;
			expect_q.push_back(e);
			model_st = nst;
			n++;
		end
	endtask

	// every word that leaves the DUT must match the oldest expectation
	always @(negedge clk) begin
		expect_t e;
		if (arst_n) begin
			if (ctl_valid) begin
				if (expect_q.size() == 0) begin
					fail_run("ctl_valid rose with no accepted instruction behind it");
				end else begin
					e = expect_q.pop_front();
					compare_control(ctl, e.ctl);
					compare_state(state, e.st);
				end
			end else if (expect_q.size() != 0) begin
				fail_run("ctl_valid stayed low after an accepted fetch edge");
			end
		end
	end

	initial begin
		int n;
		logic [31:0] r;
		logic [31:0] hi;
		logic [7:0] op;
		logic [7:0] gv;
		logic [63:0] loc;
		fetch_valid = 1'b0;
		fetch = '0;
		g = 8'd0;
		model_st = '0;

		n = 0;
		while (arst_n !== 1'b1) begin
			if (n == RESET_WAIT)
				fail_run("reset never released");
			@(posedge clk);
			n++;
		end
		#1;

		// quiet after reset, pointers at zero
		@(negedge clk);
		check_level("ctl_valid", ctl_valid, 1'b0);
		check_level("stall", stall, 1'b0);
		compare_state(state, '0);
		@(posedge clk);
		#1;

		// marginal X with G = 32: six incrl, then the ADD itself
		issue(pack_fetch(64'h100, 8'h20, 8'd5, 16'h0328), 8'd32);

		// register and immediate ALU, logic, loads and stores with named X
		repeat (40) begin
			r = $random(seed);
			op = ALU_ROWS[int'(r[23:16]) % 7] | {5'd0, r[2:0]};
			gv = 8'd32 + 8'(int'(r[31:24]) % 200);
			hi = $random(seed);
			loc = {hi, $random(seed)} & ~64'd3;
			issue(pack_fetch(loc, op, pick_named_x(gv, model_st.l, hi), r[15:0]), gv);
		end

		// unsupported rows, TRAP, TRIP on both sides of memory
		for (int k = 0; k < 15; k++) begin
			r = $random(seed);
			issue(pack_fetch(64'h2000 + 64'(4 * k), BAD_OPS[k], r[23:16], r[15:0]), 8'd40);
		end
		issue(pack_fetch(64'h3000, 8'h00, 8'd0, 16'h0102), 8'd40);
		issue(pack_fetch(64'h3004, 8'hff, 8'd1, 16'h0203), 8'd40);
		issue(pack_fetch(64'h8000_0000_0000_1000, 8'hff, 8'd1, 16'h0203), 8'd40);

		// relative addressing, forward and backward
		repeat (24) begin
			r = $random(seed);
			case (r[25:24])
			2'd0, 2'd1: op = 8'h40 | {3'd0, r[4:0]};  // Bcc and PBcc
			2'd2: op = 8'hf0 | {7'd0, r[5]};        // JMP
			default: op = 8'hf4 | {7'd0, r[5]};     // GETA
			endcase
			hi = $random(seed);
			loc = {hi, $random(seed)} & ~64'd3;
			issue(pack_fetch(loc, op, pick_named_x(8'd64, model_st.l, hi), r[23:8]), 8'd64);
		end

		// wyde immediates, SET through ANDN
		repeat (24) begin
			r = $random(seed);
			op = 8'he0 | {4'd0, r[27:24]};
			issue(pack_fetch(64'h4000, op, pick_named_x(8'd80, model_st.l, r), r[15:0]), 8'd80);
		end

		// G = 255: claim every slot up to X = 254, one incrl per edge
		issue(pack_fetch(64'h5000, 8'he0, 8'd254, 16'hbeef), 8'd255);
		fetch_valid = 1'b0;

		n = 0;
		while (expect_q.size() != 0 && n < DRAIN_WAIT) begin
			@(posedge clk);
			n++;
		end
		if (expect_q.size() != 0) begin
			$display("control words still outstanding at the end of the run");
			$display("*** TEST FAILED ***");
			$fatal(1, "outstanding control words");
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== inst_decoder.f ====
design/mmix_isa_pkg.sv
design/mmix_decode_pkg.sv
design/opcode_classifier.sv
design/operand_decoder.sv
design/stack_dispatch.sv
design/inst_decoder.sv
bench/tb_clock.sv
bench/inst_decoder_tb.sv

// ==== Makefile ====
# Verilator flow for the register-stack front end
# override on the command line, e.g. make sim JOBS=8

VERILATOR  ?= verilator
FILELIST   ?= inst_decoder.f
TB_TOP     ?= inst_decoder_tb
LINT_TOP   ?= inst_decoder
BUILD_DIR  ?= obj_dir
JOBS       ?= 4
LINT_FLAGS ?= -Wall -Wno-fatal
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

# the binary exits non-zero on $$fatal, so make fails with it
sim:
	$(VERILATOR) $(SIM_FLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)
